// ==== filelist.f ====
+incdir+dv
hdl/trace_pkg.sv
hdl/stage_tracker.sv
hdl/stamp_store.sv
hdl/hazard_log.sv
hdl/trace_emitter.sv
hdl/pipe_trace_top.sv
dv/tb_pipe_trace.sv

// ==== dv/tb_trace_ref.svh ====
//////////////////////////////////////////////////////////////////////
// Trace reference model
// LFSR stimulus source and a cycle model of the stage chain, stamp
// table and hazard counters, included inside the testbench module
//////////////////////////////////////////////////////////////////////

`ifndef TB_TRACE_REF_SVH
`define TB_TRACE_REF_SVH

localparam int          depth     = trace_depth_default;
localparam logic [31:0] lfsr_taps = 32'h80200003;

logic [31:0]     lfsr_state = 32'd49;

// Model state where stage 1 is decode and stage 4 is write-back
logic [15:0]     m_cycle;
logic [id_w-1:0] m_fetch;
logic            m_valid  [1:4];
logic [id_w-1:0] m_id     [1:4];
logic [31:0]     m_word   [depth];
stage_stamps_t   m_stamps [depth];
hazard_counts_t  m_counts;
logic            m_trace;
trace_record_t   exp_q [$];

// Galois LFSR stepped once per bit taken
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ lfsr_taps;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_bit()};
    end
    return r;
endfunction

// Record for the instruction leaving write-back at cycle wb
function automatic trace_record_t expected_record(input logic [id_w-1:0] id,
                                                  input logic [15:0]     wb);
    trace_record_t r;
    r.seq_id     = id;
    r.instr_word = m_word[id];
    r.stamps     = m_stamps[id];
    r.wb_cycle   = wb;
    return r;
endfunction

// One clock of the model with the inputs the DUT samples at the next edge
task automatic model_step(input logic rst_n, input logic stall_in, input logic flush_in,
                          input stall_cause_t sc, input flush_cause_t fc,
                          input logic [31:0] word);
    logic go;
    int   s;
    go      = rst_n && !stall_in && !flush_in;
    m_trace = go && m_valid[4];
    if (!rst_n) begin
        m_cycle  = '0;
        m_fetch  = '0;
        m_counts = '0;
        exp_q.delete();
        for (s = 1; s <= 4; s++) begin
            m_valid[s] = 1'b0;
            m_id[s]    = '0;
        end
    end else begin
        m_counts.pc_stall_cycles += 16'(stall_in && sc.pc_stall &&
                                        m_counts.pc_stall_cycles != 16'hffff);
        m_counts.if_id_stall_cycles += 16'(stall_in && sc.if_id_stall &&
                                           m_counts.if_id_stall_cycles != 16'hffff);
        m_counts.if_flush_cycles += 16'(flush_in && fc.if_flush &&
                                        m_counts.if_flush_cycles != 16'hffff);
        m_counts.id_flush_cycles += 16'(flush_in && fc.id_flush &&
                                        m_counts.id_flush_cycles != 16'hffff);
        if (go) begin
            if (m_valid[4]) begin
                exp_q.push_back(expected_record(m_id[4], m_cycle));
            end
            if (m_valid[1]) begin
                m_word[m_id[1]]                = word;
                m_stamps[m_id[1]].decode_cycle = m_cycle;
            end
            if (m_valid[2]) begin
                m_stamps[m_id[2]].execute_cycle = m_cycle;
            end
            if (m_valid[3]) begin
                m_stamps[m_id[3]].memory_cycle = m_cycle;
            end
            for (s = 4; s > 1; s--) begin
                m_valid[s] = m_valid[s-1];
                m_id[s]    = m_id[s-1];
            end
            m_valid[1] = 1'b1;
            m_id[1]    = m_fetch;
            m_fetch    = id_w'((m_fetch + 1) % depth);
        end
        m_cycle = m_cycle + 1'b1;
    end
endtask

`endif

// ==== dv/tb_pipe_trace.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace testbench
// Plays the CPU, runs a cycle model beside the DUT and checks every
// trace record and the hazard counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_pipe_trace;

    import trace_pkg::*;

    // Stimulus stays under 400 cycles
    localparam int max_cycles = 1200;

    logic           clk = 1'b0;
    logic           rst;
    logic           stall;
    logic           flush;
    stall_cause_t   stall_cause;
    flush_cause_t   flush_cause;
    logic [31:0]    decode_word;
    logic           trace_valid;
    trace_record_t  trace_record;
    hazard_counts_t hazard_counts;

    int             value_errs  = 0;
    int             record_errs = 0;
    int             cycles      = 0;
    bit             model_live  = 1'b0;
    bit             clean;
    int             rec_idx;
    trace_record_t  exp_rec;

    `include "tb_trace_ref.svh"

    pipe_trace_top #(.trace_depth(16), .cycle_w(16)) pipe_trace_top_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .stall_cause(stall_cause),
        .flush_cause(flush_cause), .decode_word(decode_word), .trace_valid(trace_valid),
        .trace_record(trace_record), .hazard_counts(hazard_counts)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [1:0] cause_bits();
        return 2'(rand_bits(2));
    endfunction

    function automatic logic [1:0] nonzero_cause();
        logic [1:0] c;
        c = cause_bits();
        while (c == 2'b00) begin
            c = cause_bits();
        end
        return c;
    endfunction

    task automatic drive(input logic st, input logic fl, input logic [1:0] sc,
                         input logic [1:0] fc);
        @(posedge clk);
        #1;
        stall       = st;
        flush       = fl;
        stall_cause = sc;
        flush_cause = fc;
        decode_word = rand_bits(32);
    endtask

    // Causes toggle freely while the pipeline runs
    task automatic run_cycles(input int n);
        repeat (n) begin
            drive(1'b0, 1'b0, cause_bits(), cause_bits());
        end
    endtask

    task automatic freeze_burst(input logic is_flush, input int len);
        repeat (len) begin
            if (is_flush) begin
                drive(1'b0, 1'b1, cause_bits(), nonzero_cause());
            end else begin
                drive(1'b1, 1'b0, nonzero_cause(), cause_bits());
            end
        end
    endtask

    task automatic report_counts();
        $display("Error counts: %0d wrong values, %0d missing or extra records, %0d pending",
                 value_errs, record_errs, exp_q.size());
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparison at the falling edge where the outputs are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (model_live) begin
            if (hazard_counts !== m_counts) begin
                $display("ERR %0t: hazard_counts %h, expected %h", $time, hazard_counts,
                         m_counts);
                value_errs++;
            end
            if (trace_valid && !m_trace) begin
                $display("Unexpected trace record at %0t with seq_id %0d", $time,
                         trace_record.seq_id);
                record_errs++;
            end else if (!trace_valid && m_trace) begin
                $display("Expected trace record did not appear at %0t", $time);
                record_errs++;
                void'(exp_q.pop_front());
            end else if (trace_valid) begin
                exp_rec = exp_q.pop_front();
                if (trace_record !== exp_rec) begin
                    $display("ERR %0t: trace_record %h, expected %h", $time, trace_record,
                             exp_rec);
                    value_errs++;
                end
                // Record k follows the fixed schedule while nothing has frozen since reset
                if (clean && (trace_record.seq_id != id_w'(rec_idx) ||
                              trace_record.stamps.decode_cycle != 16'(rec_idx + 1) ||
                              trace_record.stamps.execute_cycle != 16'(rec_idx + 2) ||
                              trace_record.stamps.memory_cycle != 16'(rec_idx + 3) ||
                              trace_record.wb_cycle != 16'(rec_idx + 4) ||
                              m_cycle != 16'(rec_idx + 5))) begin
                    $display("ERR %0t: free run record %0d off schedule", $time, rec_idx);
                    value_errs++;
                end
                rec_idx++;
            end
        end
        if (!rst) begin
            clean   = 1'b1;
            rec_idx = 0;
        end else if (stall || flush) begin
            clean = 1'b0;
        end
        model_step(rst, stall, flush, stall_cause, flush_cause, decode_word);
        model_live = 1'b1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            report_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        stall_cause = '0;
        flush_cause = '0;
        decode_word = '0;
        run_cycles(16);
        rst = 1'b1;
        // Free run long enough for the ids to wrap
        run_cycles(40);
        for (int b = 0; b < 10; b++) begin
            run_cycles(1 + rand_bits(2));
            freeze_burst(1'b0, 1 + rand_bits(2));
        end
        for (int b = 0; b < 10; b++) begin
            run_cycles(1 + rand_bits(2));
            freeze_burst(1'b1, 1 + rand_bits(2));
        end
        // Stall and flush mixed and sometimes in the same cycle
        repeat (60) begin
            drive(rand_bits(2) == 0, rand_bits(2) == 0, nonzero_cause(), nonzero_cause());
        end
        // Reset in the middle of traffic
        run_cycles(20);
        rst = 1'b0;
        run_cycles(4);
        rst = 1'b1;
        run_cycles(40);
        freeze_burst(1'b0, 3);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        report_counts();
        if (value_errs == 0 && record_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/pipe_trace_top.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace top
// Instruction tracer for a five stage in-order CPU, running beside
// the pipeline and emitting one record per retired instruction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pipe_trace_top #(
    parameter int trace_depth = trace_pkg::trace_depth_default,
    parameter int cycle_w     = trace_pkg::cycle_w_default
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  trace_pkg::stall_cause_t       stall_cause,
    input  trace_pkg::flush_cause_t       flush_cause,
    input  logic [trace_pkg::instr_w-1:0] decode_word,
    output logic                          trace_valid,
    output trace_pkg::trace_record_t      trace_record,
    output trace_pkg::hazard_counts_t     hazard_counts
);

    import trace_pkg::*;

    localparam int id_bits = $clog2(trace_depth);

    logic               advance;
    logic               dec_valid;
    logic               ex_valid;
    logic               mem_valid;
    logic               wb_valid;
    logic [id_bits-1:0] dec_id;
    logic [id_bits-1:0] ex_id;
    logic [id_bits-1:0] mem_id;
    logic [id_bits-1:0] wb_id;
    logic [cycle_w-1:0] cycle;
    logic [instr_w-1:0] rd_word;
    stage_stamps_t      rd_stamps;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    stage_tracker #(.trace_depth(trace_depth)) stage_tracker_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .advance(advance),
        .dec_valid(dec_valid), .ex_valid(ex_valid), .mem_valid(mem_valid),
        .wb_valid(wb_valid), .dec_id(dec_id), .ex_id(ex_id), .mem_id(mem_id),
        .wb_id(wb_id), .cycle(cycle)
    );

    stamp_store #(.trace_depth(trace_depth)) stamp_store_i (
        .clk(clk), .rst(rst), .advance(advance), .dec_valid(dec_valid),
        .ex_valid(ex_valid), .mem_valid(mem_valid), .dec_id(dec_id), .ex_id(ex_id),
        .mem_id(mem_id), .wb_id(wb_id), .cycle(cycle), .decode_word(decode_word),
        .rd_word(rd_word), .rd_stamps(rd_stamps)
    );

    hazard_log hazard_log_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .stall_cause(stall_cause),
        .flush_cause(flush_cause), .hazard_counts(hazard_counts)
    );

    trace_emitter trace_emitter_i (
        .clk(clk), .rst(rst), .advance(advance), .wb_valid(wb_valid), .wb_id(wb_id),
        .cycle(cycle), .rd_word(rd_word), .rd_stamps(rd_stamps),
        .trace_valid(trace_valid), .trace_record(trace_record)
    );

    // Record structs are sized by the package defaults
    a_widths: assert property (
        @(posedge clk)
            (trace_depth == trace_depth_default) && (cycle_w == cycle_w_default)
    );

endmodule

`default_nettype wire

// ==== hdl/trace_emitter.sv ====
//////////////////////////////////////////////////////////////////////
// Trace emitter
// Builds the completed record as an instruction leaves write-back and
// presents it with a one cycle valid pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module trace_emitter (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  advance,
    input  logic                                  wb_valid,
    input  logic [trace_pkg::id_w-1:0]            wb_id,
    input  logic [trace_pkg::cycle_w_default-1:0] cycle,
    input  logic [trace_pkg::instr_w-1:0]         rd_word,
    input  trace_pkg::stage_stamps_t              rd_stamps,
    output logic                                  trace_valid,
    output trace_pkg::trace_record_t              trace_record
);

    import trace_pkg::*;

    trace_record_t record_d;
    logic          retire;

    // Instruction leaves write-back this cycle
    assign retire = advance && wb_valid;

    always_comb begin
        record_d.seq_id     = wb_id;
        record_d.instr_word = rd_word;
        record_d.stamps     = rd_stamps;
        record_d.wb_cycle   = cycle;
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            trace_record <= record_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Stamps come from three stage writes and the tracker counter.
    // Holds until the 16 bit cycle counter wraps
    a_stamps_ordered: assert property (
        @(posedge clk) disable iff (!rst)
            trace_valid |->
                (trace_record.stamps.decode_cycle < trace_record.stamps.execute_cycle) &&
                (trace_record.stamps.execute_cycle < trace_record.stamps.memory_cycle) &&
                (trace_record.stamps.memory_cycle < trace_record.wb_cycle)
    );

endmodule

`default_nettype wire

// ==== hdl/hazard_log.sv ====
//////////////////////////////////////////////////////////////////////
// Hazard log
// Saturating per-cause counters of stall and flush cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module hazard_log (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    input  trace_pkg::stall_cause_t   stall_cause,
    input  trace_pkg::flush_cause_t   flush_cause,
    output trace_pkg::hazard_counts_t hazard_counts
);

    import trace_pkg::*;

    hazard_counts_t counts_q;
    hazard_counts_t counts_d;

    // Add one unless already at all ones
    function automatic logic [count_w-1:0] sat_inc(input logic [count_w-1:0] value,
                                                   input logic               hit);
        if (hit && (value != '1)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    // Several cause bits may count in the same cycle
    always_comb begin
        counts_d.pc_stall_cycles =
            sat_inc(counts_q.pc_stall_cycles, stall && stall_cause.pc_stall);
        counts_d.if_id_stall_cycles =
            sat_inc(counts_q.if_id_stall_cycles, stall && stall_cause.if_id_stall);
        counts_d.if_flush_cycles =
            sat_inc(counts_q.if_flush_cycles, flush && flush_cause.if_flush);
        counts_d.id_flush_cycles =
            sat_inc(counts_q.id_flush_cycles, flush && flush_cause.id_flush);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            counts_q <= '0;
        end else begin
            counts_q <= counts_d;
        end
    end

    // Visible one cycle after the sampled cycle
    assign hazard_counts = counts_q;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // The CPU names a reason for every freeze it requests
    a_stall_cause: assert property (
        @(posedge clk) disable iff (!rst)
            stall |-> (|stall_cause)
    );

    a_flush_cause: assert property (
        @(posedge clk) disable iff (!rst)
            flush |-> (|flush_cause)
    );

endmodule

`default_nettype wire

// ==== hdl/stamp_store.sv ====
//////////////////////////////////////////////////////////////////////
// Stamp store
// Per sequence id table of instruction words and stage exit stamps,
// written as the pipeline advances and read at write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module stamp_store #(
    parameter int trace_depth = trace_pkg::trace_depth_default
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  advance,
    input  logic                                  dec_valid,
    input  logic                                  ex_valid,
    input  logic                                  mem_valid,
    input  logic [$clog2(trace_depth)-1:0]        dec_id,
    input  logic [$clog2(trace_depth)-1:0]        ex_id,
    input  logic [$clog2(trace_depth)-1:0]        mem_id,
    input  logic [$clog2(trace_depth)-1:0]        wb_id,
    input  logic [trace_pkg::cycle_w_default-1:0] cycle,
    input  logic [trace_pkg::instr_w-1:0]         decode_word,
    output logic [trace_pkg::instr_w-1:0]         rd_word,
    output trace_pkg::stage_stamps_t              rd_stamps
);

    import trace_pkg::*;

    logic [instr_w-1:0] word_mem  [trace_depth];
    stage_stamps_t      stamp_mem [trace_depth];

    //////////////////////////////////////////////////////////////////////
    // Table writes
    //////////////////////////////////////////////////////////////////////

    // An advancing cycle is the last one the instruction spends in its
    // stage, so the current cycle is its exit stamp
    always_ff @(posedge clk) begin
        if (advance) begin
            if (dec_valid) begin
                word_mem[dec_id]               <= decode_word;
                stamp_mem[dec_id].decode_cycle <= cycle;
            end
            if (ex_valid) begin
                stamp_mem[ex_id].execute_cycle <= cycle;
            end
            if (mem_valid) begin
                stamp_mem[mem_id].memory_cycle <= cycle;
            end
        end
    end

    // Write-back slot read in the same cycle the record is built
    assign rd_word   = word_mem[wb_id];
    assign rd_stamps = stamp_mem[wb_id];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Ids in flight come from the tracker and never collide
    a_dec_ex_slots: assert property (
        @(posedge clk) disable iff (!rst)
            (advance && dec_valid && ex_valid) |-> (dec_id != ex_id)
    );

    a_dec_mem_slots: assert property (
        @(posedge clk) disable iff (!rst)
            (advance && dec_valid && mem_valid) |-> (dec_id != mem_id)
    );

    a_ex_mem_slots: assert property (
        @(posedge clk) disable iff (!rst)
            (advance && ex_valid && mem_valid) |-> (ex_id != mem_id)
    );

endmodule

`default_nettype wire

// ==== hdl/stage_tracker.sv ====
//////////////////////////////////////////////////////////////////////
// Stage tracker
// Free running cycle counter and the chain of sequence ids and valid
// flags through fetch, decode, execute, memory and write-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module stage_tracker #(
    parameter int trace_depth = trace_pkg::trace_depth_default
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  stall,
    input  logic                                  flush,
    output logic                                  advance,
    output logic                                  dec_valid,
    output logic                                  ex_valid,
    output logic                                  mem_valid,
    output logic                                  wb_valid,
    output logic [$clog2(trace_depth)-1:0]        dec_id,
    output logic [$clog2(trace_depth)-1:0]        ex_id,
    output logic [$clog2(trace_depth)-1:0]        mem_id,
    output logic [$clog2(trace_depth)-1:0]        wb_id,
    output logic [trace_pkg::cycle_w_default-1:0] cycle
);

    localparam int id_bits = $clog2(trace_depth);

    // Occupancy of one stage
    typedef struct packed {
        logic               valid;
        logic [id_bits-1:0] id;
    } stage_slot_t;

    logic [id_bits-1:0] fetch_id;
    stage_slot_t        dec_q;
    stage_slot_t        ex_q;
    stage_slot_t        mem_q;
    stage_slot_t        wb_q;

    // Id after the given one, wrapping at the table depth
    function automatic logic [id_bits-1:0] next_id(input logic [id_bits-1:0] id);
        if (id == id_bits'(trace_depth - 1)) begin
            return '0;
        end
        return id + 1'b1;
    endfunction

    // Whole pipeline freezes on stall or flush
    assign advance = rst && !stall && !flush;

    //////////////////////////////////////////////////////////////////////
    // Cycle counter and stage chain
    //////////////////////////////////////////////////////////////////////

    // First clock with rst high reads as cycle 0
    always_ff @(posedge clk) begin
        if (!rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // Fetch is always occupied, so decode becomes valid on the first advance
    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_id <= '0;
            dec_q    <= '0;
            ex_q     <= '0;
            mem_q    <= '0;
            wb_q     <= '0;
        end else if (advance) begin
            fetch_id <= next_id(fetch_id);
            dec_q    <= '{valid: 1'b1, id: fetch_id};
            ex_q     <= dec_q;
            mem_q    <= ex_q;
            wb_q     <= mem_q;
        end
    end

    assign dec_valid = dec_q.valid;
    assign ex_valid  = ex_q.valid;
    assign mem_valid = mem_q.valid;
    assign wb_valid  = wb_q.valid;
    assign dec_id    = dec_q.id;
    assign ex_id     = ex_q.id;
    assign mem_id    = mem_q.id;
    assign wb_id     = wb_q.id;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Younger stage holds the id right after the older one
    property p_ids_adjacent(logic both_valid, logic [id_bits-1:0] young,
                            logic [id_bits-1:0] old);
        @(posedge clk) disable iff (!rst)
            both_valid |-> (young == next_id(old));
    endproperty

    a_fetch_dec: assert property (p_ids_adjacent(dec_valid, fetch_id, dec_id));
    a_dec_ex:    assert property (p_ids_adjacent(dec_valid && ex_valid, dec_id, ex_id));
    a_ex_mem:    assert property (p_ids_adjacent(ex_valid && mem_valid, ex_id, mem_id));
    a_mem_wb:    assert property (p_ids_adjacent(mem_valid && wb_valid, mem_id, wb_id));

endmodule

`default_nettype wire

// ==== hdl/trace_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline trace package
// Widths, stall and flush cause encodings and the record structs
// shared by the instruction tracer blocks
//////////////////////////////////////////////////////////////////////

`default_nettype none

package trace_pkg;

    // Default sizes that the top level parameters must match
    localparam int trace_depth_default = 16;
    localparam int cycle_w_default     = 16;
    localparam int instr_w             = 32;

    // Derived widths
    localparam int id_w    = $clog2(trace_depth_default);
    localparam int count_w = 16;

    //////////////////////////////////////////////////////////////////////
    // Hazard causes
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic pc_stall;
        logic if_id_stall;
    } stall_cause_t;

    typedef struct packed {
        logic if_flush;
        logic id_flush;
    } flush_cause_t;

    // Saturating cycle counts per cause
    typedef struct packed {
        logic [count_w-1:0] pc_stall_cycles;
        logic [count_w-1:0] if_id_stall_cycles;
        logic [count_w-1:0] if_flush_cycles;
        logic [count_w-1:0] id_flush_cycles;
    } hazard_counts_t;

    //////////////////////////////////////////////////////////////////////
    // Trace records
    //////////////////////////////////////////////////////////////////////

    // Cycle in which the instruction left each stage
    typedef struct packed {
        logic [cycle_w_default-1:0] decode_cycle;
        logic [cycle_w_default-1:0] execute_cycle;
        logic [cycle_w_default-1:0] memory_cycle;
    } stage_stamps_t;

    // One completed instruction of 100 bits
    typedef struct packed {
        logic [id_w-1:0]            seq_id;
        logic [instr_w-1:0]         instr_word;
        stage_stamps_t              stamps;
        logic [cycle_w_default-1:0] wb_cycle;
    } trace_record_t;

endpackage

`default_nettype wire
